/* src/cpu_params.svh */
`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

// Datapath widths
`define CPU_DBITS       32
`define CPU_REGNO_BITS  4
`define CPU_IMM_BITS    16

// Fetch starts here after reset
`define CPU_START_PC    32'h0000_0100

// Memory depths in words
`define CPU_IMEM_WORDS  256
`define CPU_DMEM_WORDS  1024

// Memory-mapped I/O
`define CPU_ADDR_HEX    32'hFFFF_F000
`define CPU_ADDR_LEDR   32'hFFFF_F020
`define CPU_ADDR_KEY    32'hFFFF_F080
`define CPU_HEX_BITS    24
`define CPU_LEDR_BITS   10
`define CPU_KEY_BITS    4
`define CPU_HEX_RESET   24'hFEDEAD

`endif

/* src/cpu_pkg.sv */
`default_nettype none

`include "cpu_params.svh"

package cpu_pkg;

  typedef logic [`CPU_DBITS-1:0] word_t;
  typedef logic [`CPU_REGNO_BITS-1:0] regno_t;

  // Primary opcode in instruction bits 31:26
  typedef enum logic [5:0] {
    OP1_ALUR = 6'b000000,
    OP1_LW   = 6'b010010,
    OP1_SW   = 6'b011010,
    OP1_ADDI = 6'b100000,
    OP1_ANDI = 6'b100100,
    OP1_ORI  = 6'b100101,
    OP1_XORI = 6'b100110
  } op1_e;

  // Secondary opcode for ALUR in bits 25:18
  typedef enum logic [7:0] {
    OP2_EQ   = 8'b00001000,
    OP2_LT   = 8'b00001001,
    OP2_LE   = 8'b00001010,
    OP2_NE   = 8'b00001011,
    OP2_ADD  = 8'b00100000,
    OP2_AND  = 8'b00100100,
    OP2_OR   = 8'b00100101,
    OP2_XOR  = 8'b00100110,
    OP2_SUB  = 8'b00101000,
    OP2_NAND = 8'b00101100,
    OP2_NOR  = 8'b00101101,
    OP2_NXOR = 8'b00101110,
    OP2_RSHF = 8'b00110000,
    OP2_LSHF = 8'b00110001
  } op2_e;

  typedef struct packed {
    op1_e       op1;
    op2_e       op2;
    logic [5:0] pad;
    regno_t     rd;
    regno_t     rs;
    regno_t     rt;
  } r_fmt_t;

  typedef struct packed {
    op1_e                    op1;
    logic [1:0]              pad;
    logic [`CPU_IMM_BITS-1:0] imm;
    regno_t                  rs;
    regno_t                  rt;
  } i_fmt_t;

  // One instruction word seen as either format
  typedef union packed {
    r_fmt_t r;
    i_fmt_t i;
  } instr_t;

endpackage

`default_nettype wire

/* src/cpu_stage_if.sv */
`timescale 1ns/1ns
`default_nettype none

// **************************************************
// ID/EX pipeline register contents
// **************************************************
interface id_ex_if;
  import cpu_pkg::*;

  logic   valid;
  op1_e   op1;
  op2_e   op2;
  word_t  val1;
  word_t  val2;
  word_t  imm_sx;
  regno_t wregno;
  logic   wr_reg;
  logic   rd_mem;
  logic   wr_mem;

  modport producer (
    output valid, op1, op2, val1, val2, imm_sx, wregno, wr_reg, rd_mem, wr_mem
  );

  modport consumer (
    input valid, op1, op2, val1, val2, imm_sx, wregno, wr_reg, rd_mem, wr_mem
  );

  // Decode only needs the destination for its hazard check
  modport monitor (
    input valid, wregno, wr_reg
  );
endinterface

// **************************************************
// EX/MEM pipeline register contents
// **************************************************
interface ex_mem_if;
  import cpu_pkg::*;

  logic   valid;
  word_t  alu_out;
  word_t  store_data;
  regno_t wregno;
  logic   wr_reg;
  logic   rd_mem;
  logic   wr_mem;

  modport producer (
    output valid, alu_out, store_data, wregno, wr_reg, rd_mem, wr_mem
  );

  modport consumer (
    input valid, alu_out, store_data, wregno, wr_reg, rd_mem, wr_mem
  );

  modport monitor (
    input valid, wregno, wr_reg
  );
endinterface

`default_nettype wire

/* src/fetch_stage.sv */
`timescale 1ns/1ns
`default_nettype none

`include "cpu_params.svh"

module fetch_stage (
  input  logic            clk,
  input  logic            reset,
  input  logic            imem_we,
  input  logic [7:0]      imem_addr,
  input  cpu_pkg::word_t  imem_wdata,
  input  logic            stall,
  output cpu_pkg::instr_t instr,
  output logic            instr_valid
);
  import cpu_pkg::*;

  localparam int IMEM_AW = $clog2(`CPU_IMEM_WORDS);

  word_t pc;
  word_t imem [`CPU_IMEM_WORDS];

  // Program load port ignores reset
  always_ff @(posedge clk) begin
    if (imem_we) begin
      imem[imem_addr] <= imem_wdata;
    end
  end

  // PC and fetch latch both freeze while decode stalls
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      pc          <= `CPU_START_PC;
      instr_valid <= 1'b0;
    end else if (!stall) begin
      pc          <= pc + word_t'(4);
      instr_valid <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (!stall) begin
      instr <= imem[pc[IMEM_AW+1:2]];
    end
  end

endmodule

`default_nettype wire

/* src/decode_stage.sv */
`timescale 1ns/1ns
`default_nettype none

`include "cpu_params.svh"

module decode_stage (
  input  logic            clk,
  input  logic            reset,
  input  cpu_pkg::instr_t instr,
  input  logic            instr_valid,
  output logic            stall,
  id_ex_if.producer       id_ex,
  id_ex_if.monitor        id_ex_mon,
  ex_mem_if.monitor       ex_mem_mon,
  input  logic            wb_en,
  input  cpu_pkg::regno_t wb_regno,
  input  cpu_pkg::word_t  wb_data
);
  import cpu_pkg::*;

  word_t  regs [1 << `CPU_REGNO_BITS];
  op1_e   op1;
  regno_t rs;
  regno_t rt;
  logic   is_alur;
  logic   is_alui;
  logic   uses_rt;
  logic   wr_reg;
  regno_t wregno;
  word_t  imm_sx;
  logic   issue;

  // r0 reads as zero, and a write in flight is forwarded
  function automatic word_t read_reg(regno_t r);
    if (r == '0) begin
      return '0;
    end
    if (wb_en && wb_regno == r) begin
      return wb_data;
    end
    return regs[r];
  endfunction

  // Pending write to r in EX or MEM
  function automatic logic pending(regno_t r);
    return (id_ex_mon.valid && id_ex_mon.wr_reg && id_ex_mon.wregno == r) ||
           (ex_mem_mon.valid && ex_mem_mon.wr_reg && ex_mem_mon.wregno == r);
  endfunction

  always_ff @(posedge clk) begin
    if (wb_en && wb_regno != '0) begin
      regs[wb_regno] <= wb_data;
    end
  end

  // **************************************************
  // Field decode and control
  // **************************************************
  assign op1     = instr.r.op1;
  assign rs      = instr.r.rs;
  assign rt      = instr.r.rt;
  assign is_alur = (op1 == OP1_ALUR);
  assign is_alui = (op1 inside {OP1_ADDI, OP1_ANDI, OP1_ORI, OP1_XORI});
  assign uses_rt = is_alur || (op1 == OP1_SW);
  assign wr_reg  = is_alur || is_alui || (op1 == OP1_LW);
  assign wregno  = is_alur ? instr.r.rd : rt;
  assign imm_sx  = {{(`CPU_DBITS-`CPU_IMM_BITS){instr.i.imm[`CPU_IMM_BITS-1]}}, instr.i.imm};

  // Hold until the producer reaches MEM/WB where the bypass covers it
  assign stall = instr_valid &&
                 ((rs != '0 && pending(rs)) || (uses_rt && rt != '0 && pending(rt)));
  assign issue = instr_valid && !stall;

  // **************************************************
  // ID/EX latch
  // **************************************************
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      id_ex.valid  <= 1'b0;
      id_ex.wr_reg <= 1'b0;
      id_ex.rd_mem <= 1'b0;
      id_ex.wr_mem <= 1'b0;
    end else begin
      // Bubble when stalled or nothing fetched
      id_ex.valid  <= issue;
      id_ex.wr_reg <= issue && wr_reg;
      id_ex.rd_mem <= issue && (op1 == OP1_LW);
      id_ex.wr_mem <= issue && (op1 == OP1_SW);
    end
  end

  always_ff @(posedge clk) begin
    id_ex.op1    <= op1;
    id_ex.op2    <= instr.r.op2;
    id_ex.val1   <= read_reg(rs);
    id_ex.val2   <= read_reg(rt);
    id_ex.imm_sx <= imm_sx;
    id_ex.wregno <= wregno;
  end

endmodule

`default_nettype wire

/* src/execute_stage.sv */
`timescale 1ns/1ns
`default_nettype none

`include "cpu_params.svh"

module execute_stage (
  input  logic       clk,
  input  logic       reset,
  id_ex_if.consumer  id_ex,
  ex_mem_if.producer ex_mem
);
  import cpu_pkg::*;

  localparam int SHAMT_BITS = $clog2(`CPU_DBITS);

  word_t a;
  word_t b;
  word_t imm;
  word_t alu_out;

  assign a   = id_ex.val1;
  assign b   = id_ex.val2;
  assign imm = id_ex.imm_sx;

  // **************************************************
  // ALU
  // **************************************************
  always_comb begin
    alu_out = '0;
    case (id_ex.op1)
      OP1_ALUR: begin
        case (id_ex.op2)
          OP2_EQ:   alu_out = word_t'(a == b);
          OP2_LT:   alu_out = word_t'($signed(a) < $signed(b));
          OP2_LE:   alu_out = word_t'($signed(a) <= $signed(b));
          OP2_NE:   alu_out = word_t'(a != b);
          OP2_ADD:  alu_out = a + b;
          OP2_SUB:  alu_out = a - b;
          OP2_AND:  alu_out = a & b;
          OP2_OR:   alu_out = a | b;
          OP2_XOR:  alu_out = a ^ b;
          OP2_NAND: alu_out = ~(a & b);
          OP2_NOR:  alu_out = ~(a | b);
          OP2_NXOR: alu_out = ~(a ^ b);
          // Shift amount is the low bits of rt only
          OP2_RSHF: alu_out = $signed(a) >>> b[SHAMT_BITS-1:0];
          OP2_LSHF: alu_out = a << b[SHAMT_BITS-1:0];
          default:  alu_out = '0;
        endcase
      end
      // Address generation shares the adder with ADDI
      OP1_LW, OP1_SW, OP1_ADDI: alu_out = a + imm;
      OP1_ANDI: alu_out = a & imm;
      OP1_ORI:  alu_out = a | imm;
      OP1_XORI: alu_out = a ^ imm;
      default:  alu_out = '0;
    endcase
  end

  // **************************************************
  // EX/MEM latch
  // **************************************************
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      ex_mem.valid  <= 1'b0;
      ex_mem.wr_reg <= 1'b0;
      ex_mem.rd_mem <= 1'b0;
      ex_mem.wr_mem <= 1'b0;
    end else begin
      ex_mem.valid  <= id_ex.valid;
      ex_mem.wr_reg <= id_ex.wr_reg;
      ex_mem.rd_mem <= id_ex.rd_mem;
      ex_mem.wr_mem <= id_ex.wr_mem;
    end
  end

  always_ff @(posedge clk) begin
    ex_mem.alu_out    <= alu_out;
    ex_mem.store_data <= b;
    ex_mem.wregno     <= id_ex.wregno;
  end

endmodule

`default_nettype wire

/* src/memory_stage.sv */
`timescale 1ns/1ns
`default_nettype none

`include "cpu_params.svh"

module memory_stage (
  input  logic                      clk,
  input  logic                      reset,
  ex_mem_if.consumer                ex_mem,
  input  logic [`CPU_KEY_BITS-1:0]  key,
  output logic [`CPU_HEX_BITS-1:0]  hex,
  output logic [`CPU_LEDR_BITS-1:0] led,
  output logic                      wb_en,
  output cpu_pkg::regno_t           wb_regno,
  output cpu_pkg::word_t            wb_data
);
  import cpu_pkg::*;

  localparam int DMEM_AW = $clog2(`CPU_DMEM_WORDS);

  word_t dmem [`CPU_DMEM_WORDS];
  word_t addr;
  logic  store;
  logic  is_hex;
  logic  is_led;
  word_t load_data;

  assign addr   = ex_mem.alu_out;
  assign store  = ex_mem.valid && ex_mem.wr_mem;
  assign is_hex = (addr == `CPU_ADDR_HEX);
  assign is_led = (addr == `CPU_ADDR_LEDR);

  // KEY buttons are active low on the board
  assign load_data = (addr == `CPU_ADDR_KEY) ?
                     {{(`CPU_DBITS-`CPU_KEY_BITS){1'b0}}, ~key} :
                     dmem[addr[DMEM_AW+1:2]];

  // I/O addresses never reach data memory
  always_ff @(posedge clk) begin
    if (store && !is_hex && !is_led) begin
      dmem[addr[DMEM_AW+1:2]] <= ex_mem.store_data;
    end
  end

  // **************************************************
  // Output registers
  // **************************************************
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      hex <= `CPU_HEX_RESET;
      led <= '0;
    end else if (store) begin
      if (is_hex) begin
        hex <= ex_mem.store_data[`CPU_HEX_BITS-1:0];
      end
      if (is_led) begin
        led <= ex_mem.store_data[`CPU_LEDR_BITS-1:0];
      end
    end
  end

  // MEM/WB latch feeding the register file in decode
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      wb_en <= 1'b0;
    end else begin
      wb_en <= ex_mem.valid && ex_mem.wr_reg;
    end
  end

  always_ff @(posedge clk) begin
    wb_regno <= ex_mem.wregno;
    wb_data  <= ex_mem.rd_mem ? load_data : ex_mem.alu_out;
  end

endmodule

`default_nettype wire

/* src/cpu_top.sv */
`timescale 1ns/1ns
`default_nettype none

`include "cpu_params.svh"

module cpu_top (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      imem_we,
  input  logic [7:0]                imem_addr,
  input  cpu_pkg::word_t            imem_wdata,
  input  logic [`CPU_KEY_BITS-1:0]  key,
  output logic [`CPU_HEX_BITS-1:0]  hex,
  output logic [`CPU_LEDR_BITS-1:0] led
);
  import cpu_pkg::*;

  instr_t instr;
  logic   instr_valid;
  logic   stall;
  logic   wb_en;
  regno_t wb_regno;
  word_t  wb_data;

  id_ex_if  id_ex ();
  ex_mem_if ex_mem ();

  fetch_stage u_fetch (
    .clk         (clk),
    .reset       (reset),
    .imem_we     (imem_we),
    .imem_addr   (imem_addr),
    .imem_wdata  (imem_wdata),
    .stall       (stall),
    .instr       (instr),
    .instr_valid (instr_valid)
  );

  // Decode also owns the register file written back from memory
  decode_stage u_decode (
    .clk         (clk),
    .reset       (reset),
    .instr       (instr),
    .instr_valid (instr_valid),
    .stall       (stall),
    .id_ex       (id_ex),
    .id_ex_mon   (id_ex),
    .ex_mem_mon  (ex_mem),
    .wb_en       (wb_en),
    .wb_regno    (wb_regno),
    .wb_data     (wb_data)
  );

  execute_stage u_execute (
    .clk    (clk),
    .reset  (reset),
    .id_ex  (id_ex),
    .ex_mem (ex_mem)
  );

  memory_stage u_memory (
    .clk      (clk),
    .reset    (reset),
    .ex_mem   (ex_mem),
    .key      (key),
    .hex      (hex),
    .led      (led),
    .wb_en    (wb_en),
    .wb_regno (wb_regno),
    .wb_data  (wb_data)
  );

endmodule

`default_nettype wire

/* dv/cpu_checker.sv */
`timescale 1ns/1ns
`default_nettype none

`include "cpu_params.svh"

module cpu_checker (
  input logic                      clk,
  input logic [`CPU_HEX_BITS-1:0]  hex,
  input logic [`CPU_LEDR_BITS-1:0] led
);

  localparam int TIMEOUT_CYCLES = 200;
  // Long enough for any test program to reach its store
  localparam int SETTLE_CYCLES  = 40;

  int total_count = 0;
  int pass_count  = 0;
  int fail_count  = 0;

  // Outputs change on the rising edge, so sample on the falling one
  task automatic check_reset();
    @(negedge clk);
    total_count++;
    if (hex === `CPU_HEX_RESET && led === '0) begin
      pass_count++;
      $display("PASS reset values: hex %h led %h", hex, led);
    end else begin
      fail_count++;
      $display("FAIL %0t: reset values hex %h led %h", $time, hex, led);
    end
  endtask

  task automatic check_row(input string name, input logic on_led,
                           input logic [23:0] expected);
    logic [23:0] seen;
    logic [23:0] reset_val;
    int          cycles;
    logic        done;
    reset_val = on_led ? 24'h0 : `CPU_HEX_RESET;
    cycles    = 0;
    done      = 1'b0;
    seen      = reset_val;
    while (!done && cycles < TIMEOUT_CYCLES) begin
      @(negedge clk);
      cycles++;
      seen = on_led ? {14'b0, led} : hex;
      done = (seen !== reset_val) || (expected === reset_val && cycles >= SETTLE_CYCLES);
    end
    total_count++;
    if (!done) begin
      fail_count++;
      $display("%s timed out: %s did not change within %0d cycles", name,
               on_led ? "led" : "hex", TIMEOUT_CYCLES);
    end else if (seen !== expected) begin
      fail_count++;
      $display("FAIL %0t: %s got %h expected %h", $time, name, seen, expected);
    end else begin
      pass_count++;
      $display("PASS %s: %h after %0d cycles", name, seen, cycles);
    end
  endtask

  task automatic report();
    $display("Tests run: %0d  passed: %0d  failed: %0d", total_count, pass_count, fail_count);
  endtask

endmodule

`default_nettype wire

/* dv/tb_cpu.sv */
`timescale 1ns/1ns
`default_nettype none

`include "cpu_params.svh"

module tb_cpu;
  import cpu_pkg::*;

  localparam logic [2:0] K_ALUR = 3'd0;
  localparam logic [2:0] K_ALUI = 3'd1;
  localparam logic [2:0] K_MEM  = 3'd2;
  localparam logic [2:0] K_KEY  = 3'd3;
  localparam logic [2:0] K_LED  = 3'd4;
  localparam logic [2:0] K_R0   = 3'd5;

  // Program sits at the word that the reset PC addresses
  localparam int    PROG_BASE = (`CPU_START_PC / 4) % `CPU_IMEM_WORDS;
  localparam word_t ADDR_HEX  = `CPU_ADDR_HEX;
  localparam word_t ADDR_LEDR = `CPU_ADDR_LEDR;
  localparam word_t ADDR_KEY  = `CPU_ADDR_KEY;
  localparam logic [15:0] IMM_DATA = 16'h0040;

  typedef struct packed {
    logic [2:0]  kind;
    logic [5:0]  op1;
    logic [7:0]  op2;
    logic [15:0] a;
    logic [15:0] b;
    logic        rnd;
  } row_t;

  logic                      clk;
  logic                      reset;
  logic                      imem_we;
  logic [7:0]                imem_addr;
  word_t                     imem_wdata;
  logic [`CPU_KEY_BITS-1:0]  key;
  logic [`CPU_HEX_BITS-1:0]  hex;
  logic [`CPU_LEDR_BITS-1:0] led;

  row_t        rows [$];
  word_t       prog [16];
  logic [15:0] lfsr_state;

  cpu_top i_dut (
    .clk        (clk),
    .reset      (reset),
    .imem_we    (imem_we),
    .imem_addr  (imem_addr),
    .imem_wdata (imem_wdata),
    .key        (key),
    .hex        (hex),
    .led        (led)
  );

  cpu_checker i_chk (
    .clk (clk),
    .hex (hex),
    .led (led)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // **************************************************
  // Random bits and instruction encoding
  // **************************************************
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  task automatic take_bits(input int n, output logic [15:0] v);
    int k;
    v = '0;
    for (k = 0; k < n; k++) begin
      v = {v[14:0], lfsr_state[0]};
      lfsr_state = lfsr_step(lfsr_state);
    end
  endtask

  function automatic word_t sign_extend(input logic [15:0] v);
    return {{16{v[15]}}, v};
  endfunction

  function automatic word_t encode_i(input logic [5:0] op1, input regno_t rs,
                                     input regno_t rt, input logic [15:0] imm);
    return {op1, 2'b00, imm, rs, rt};
  endfunction

  function automatic word_t encode_r(input logic [7:0] op2, input regno_t rd,
                                     input regno_t rs, input regno_t rt);
    return {6'b000000, op2, 6'b000000, rd, rs, rt};
  endfunction

  // Reference result of one ALU operation
  function automatic word_t model_result(input logic [5:0] op1, input logic [7:0] op2,
                                         input word_t a, input word_t b);
    logic signed [31:0] sa;
    logic signed [31:0] sb;
    sa = a;
    sb = b;
    case (op1)
      OP1_ADDI: return a + b;
      OP1_ANDI: return a & b;
      OP1_ORI:  return a | b;
      OP1_XORI: return a ^ b;
      default: ;
    endcase
    case (op2)
      OP2_EQ:   return {31'b0, a == b};
      OP2_LT:   return {31'b0, sa < sb};
      OP2_LE:   return {31'b0, sa <= sb};
      OP2_NE:   return {31'b0, a != b};
      OP2_ADD:  return a + b;
      OP2_SUB:  return a - b;
      OP2_AND:  return a & b;
      OP2_OR:   return a | b;
      OP2_XOR:  return a ^ b;
      OP2_NAND: return ~(a & b);
      OP2_NOR:  return ~(a | b);
      OP2_NXOR: return ~(a ^ b);
      OP2_RSHF: return sa >>> b[4:0];
      OP2_LSHF: return a << b[4:0];
      default:  return '0;
    endcase
  endfunction

  // **************************************************
  // Test table and program builder
  // **************************************************
  task automatic add_row(input logic [2:0] kind, input logic [5:0] op1, input logic [7:0] op2,
                         input logic [15:0] a, input logic [15:0] b, input logic rnd);
    rows.push_back({kind, op1, op2, a, b, rnd});
  endtask

  task automatic build_table();
    row_t row;
    int   i;
    add_row(K_ALUR, OP1_ALUR, OP2_EQ,   16'h1234, 16'h1234, 1'b0);
    add_row(K_ALUR, OP1_ALUR, OP2_LT,   16'hFFF0, 16'h0005, 1'b0);
    add_row(K_ALUR, OP1_ALUR, OP2_LE,   16'h0007, 16'h0007, 1'b0);
    add_row(K_ALUR, OP1_ALUR, OP2_NE,   16'h0001, 16'h0001, 1'b0);
    add_row(K_ALUR, OP1_ALUR, OP2_ADD,  16'h7FFF, 16'h0001, 1'b0);
    add_row(K_ALUR, OP1_ALUR, OP2_SUB,  16'h0003, 16'h0010, 1'b0);
    add_row(K_ALUR, OP1_ALUR, OP2_AND,  16'hF0F0, 16'h3C3C, 1'b0);
    add_row(K_ALUR, OP1_ALUR, OP2_OR,   16'h0F00, 16'h00F0, 1'b0);
    add_row(K_ALUR, OP1_ALUR, OP2_XOR,  16'hAAAA, 16'h5555, 1'b0);
    add_row(K_ALUR, OP1_ALUR, OP2_NAND, 16'hFF00, 16'h0FF0, 1'b0);
    add_row(K_ALUR, OP1_ALUR, OP2_NOR,  16'h1200, 16'h0034, 1'b0);
    add_row(K_ALUR, OP1_ALUR, OP2_NXOR, 16'h1234, 16'h4321, 1'b0);
    add_row(K_ALUR, OP1_ALUR, OP2_RSHF, 16'h8000, 16'h0004, 1'b0);
    add_row(K_ALUR, OP1_ALUR, OP2_LSHF, 16'h0ABC, 16'h0008, 1'b0);
    // Every register operation again with random operands
    for (i = 0; i < 14; i++) begin
      row = rows[i];
      add_row(K_ALUR, OP1_ALUR, row.op2, 16'h0, 16'h0, 1'b1);
    end
    add_row(K_ALUI, OP1_ADDI, OP2_ADD, 16'h0100, 16'hFFFE, 1'b0);
    add_row(K_ALUI, OP1_ANDI, OP2_ADD, 16'h5A5A, 16'hFF0F, 1'b0);
    add_row(K_ALUI, OP1_ORI,  OP2_ADD, 16'h0001, 16'h8000, 1'b0);
    add_row(K_ALUI, OP1_XORI, OP2_ADD, 16'h00FF, 16'hFFFF, 1'b0);
    add_row(K_ALUI, OP1_XORI, OP2_ADD, 16'h0,    16'h0,    1'b1);
    add_row(K_MEM,  OP1_LW,   OP2_ADD, 16'hBEEF, 16'h0,    1'b0);
    add_row(K_MEM,  OP1_LW,   OP2_ADD, 16'h0,    16'h0,    1'b1);
    add_row(K_KEY,  OP1_LW,   OP2_ADD, 16'h0005, 16'h0,    1'b0);
    add_row(K_KEY,  OP1_LW,   OP2_ADD, 16'h000F, 16'h0,    1'b0);
    add_row(K_LED,  OP1_SW,   OP2_ADD, 16'h02A5, 16'h0,    1'b0);
    add_row(K_LED,  OP1_SW,   OP2_ADD, 16'h0,    16'h0,    1'b1);
    add_row(K_R0,   OP1_ADDI, OP2_ADD, 16'h1234, 16'h0,    1'b0);
  endtask

  // Every program ends with one store of src to HEX or LEDR
  task automatic build_program(input row_t row, input logic [15:0] a, input logic [15:0] b,
                               output int len, output logic on_led,
                               output logic [23:0] expected);
    word_t  result;
    regno_t src;
    on_led = 1'b0;
    src    = 4'd3;
    case (row.kind)
      K_ALUR: begin
        prog[0] = encode_i(OP1_ADDI, 4'd0, 4'd1, a);
        prog[1] = encode_i(OP1_ADDI, 4'd0, 4'd2, b);
        prog[2] = encode_r(row.op2, 4'd3, 4'd1, 4'd2);
        len     = 3;
        result  = model_result(OP1_ALUR, row.op2, sign_extend(a), sign_extend(b));
      end
      K_ALUI: begin
        prog[0] = encode_i(OP1_ADDI, 4'd0, 4'd1, a);
        prog[1] = encode_i(row.op1, 4'd1, 4'd3, b);
        len     = 2;
        result  = model_result(row.op1, row.op2, sign_extend(a), sign_extend(b));
      end
      K_MEM: begin
        prog[0] = encode_i(OP1_ADDI, 4'd0, 4'd1, a);
        prog[1] = encode_i(OP1_SW, 4'd0, 4'd1, IMM_DATA);
        prog[2] = encode_i(OP1_LW, 4'd0, 4'd3, IMM_DATA);
        len     = 3;
        result  = sign_extend(a);
      end
      K_KEY: begin
        prog[0] = encode_i(OP1_LW, 4'd0, 4'd3, ADDR_KEY[15:0]);
        len     = 1;
        result  = {28'b0, ~a[3:0]};
        on_led  = 1'b1;
      end
      K_LED: begin
        prog[0] = encode_i(OP1_ADDI, 4'd0, 4'd3, a);
        len     = 1;
        result  = sign_extend(a);
        on_led  = 1'b1;
      end
      default: begin
        prog[0] = encode_i(OP1_ADDI, 4'd0, 4'd0, a);
        len     = 1;
        result  = '0;
        src     = 4'd0;
      end
    endcase
    prog[len] = encode_i(OP1_SW, 4'd0, src, on_led ? ADDR_LEDR[15:0] : ADDR_HEX[15:0]);
    len++;
    expected = on_led ? {14'b0, result[9:0]} : result[23:0];
  endtask

  // Rewrites the whole instruction memory while reset is held
  task automatic load_program(input int len, input logic [3:0] key_value);
    int i;
    @(posedge clk);
    reset <= 1'b1;
    key   <= key_value;
    for (i = 0; i < `CPU_IMEM_WORDS; i++) begin
      @(posedge clk);
      imem_we    <= 1'b1;
      imem_addr  <= 8'(i);
      imem_wdata <= (i >= PROG_BASE && i < PROG_BASE + len) ? prog[i - PROG_BASE] : '0;
    end
    @(posedge clk);
    imem_we <= 1'b0;
    repeat (10) @(posedge clk);
    reset <= 1'b0;
  endtask

  initial begin
    row_t        row;
    int          r;
    int          len;
    logic        on_led;
    logic [23:0] expected;
    logic [15:0] a;
    logic [15:0] b;
    reset      = 1'b1;
    imem_we    = 1'b0;
    imem_addr  = '0;
    imem_wdata = '0;
    key        = '0;
    lfsr_state = 16'd59017;
    build_table();
    repeat (10) @(posedge clk);
    i_chk.check_reset();
    for (r = 0; r < rows.size(); r++) begin
      row = rows[r];
      a   = row.a;
      b   = row.b;
      if (row.rnd) begin
        take_bits(16, a);
        take_bits(16, b);
      end
      build_program(row, a, b, len, on_led, expected);
      load_program(len, a[3:0]);
      i_chk.check_row($sformatf("row %0d op1 %02h op2 %02h a %04h b %04h",
                                r, row.op1, row.op2, a, b), on_led, expected);
    end
    i_chk.report();
    if (i_chk.fail_count == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* filelist.f */
+incdir+src
src/cpu_pkg.sv
src/cpu_stage_if.sv
src/fetch_stage.sv
src/decode_stage.sv
src/execute_stage.sv
src/memory_stage.sv
src/cpu_top.sv
dv/cpu_checker.sv
dv/tb_cpu.sv

/* Bender.yml */
package:
  name: cpu_pipeline

sources:
  - include_dirs:
      - src
    files:
      - src/cpu_pkg.sv
      - src/cpu_stage_if.sv
      - src/fetch_stage.sv
      - src/decode_stage.sv
      - src/execute_stage.sv
      - src/memory_stage.sv
      - src/cpu_top.sv
  - target: test
    include_dirs:
      - src
    files:
      - dv/cpu_checker.sv
      - dv/tb_cpu.sv
